//--- include/rv_isa.svh
`ifndef RV_ISA_SVH
`define RV_ISA_SVH

// Major opcodes of the supported RV32I subset
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111

// funct3 of the integer ALU group
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL_SRA  3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

// funct7, ALT selects SUB and SRA/SRAI
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000

`endif

//--- source/rv_pkg.sv
`include "rv_isa.svh"

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        opc_op     = `RV_OPC_OP,
        opc_op_imm = `RV_OPC_OP_IMM,
        opc_lui    = `RV_OPC_LUI,
        opc_auipc  = `RV_OPC_AUIPC
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b     // LUI result
    } alu_op_e;

    // Fetched instruction entering decode
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id_t;

    // Decoded instruction with resolved operands
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        alu_op_e  alu_op;
        word_t    operand_a;
        word_t    operand_b;
        reg_idx_t rd;
        logic     writes_rd;
    } id_ex_t;

    // Retired instruction, also the register file write
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

//--- source/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch
    import rv_pkg::*;
#(
    parameter addr_t reset_pc = '0
)
(
    input  logic  i_clock,
    input  logic  i_arst_n,
    input  logic  i_stall,          // Hold the PC
    input  logic  i_redirect,       // Load the target, wins over stall
    input  addr_t i_redirect_pc,
    output addr_t o_pc
);

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_pc <= reset_pc;
        end
        else if (i_redirect)
        begin
            o_pc <= i_redirect_pc;
        end
        else if (!i_stall)
        begin
            o_pc <= o_pc + addr_t'(4);  // Next sequential word
        end
    end

endmodule

//--- source/rv_pipe_if_id.sv
`timescale 1ns/10ps

module rv_pipe_if_id
    import rv_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_arst_n,
    input  logic   i_stall,         // Keep current contents
    input  logic   i_flush,         // Load a bubble
    input  addr_t  i_pc,
    input  inst_t  i_inst,
    output if_id_t o_if_id
);

    logic  valid_q;
    addr_t pc_q;
    inst_t inst_q;

    // Flush is checked first so a redirect during a stall still squashes
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (i_flush)
        begin
            valid_q <= 1'b0;
        end
        else if (!i_stall)
        begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_stall)
        begin
            pc_q   <= i_pc;
            inst_q <= i_inst;
        end
    end

    assign o_if_id = '{valid: valid_q, pc: pc_q, inst: inst_q};

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_arst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  wb_t      i_wb,          // Write port
    output word_t    o_rs1_value,
    output word_t    o_rs2_value
);

    word_t regs [0:31];
    logic  wr_en;

    assign wr_en = i_wb.valid && (i_wb.rd != '0);   // x0 never written

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[i_wb.rd] <= i_wb.value;
        end
    end

    // Same-cycle write is visible to the read
    assign o_rs1_value = (wr_en && i_wb.rd == i_rs1) ? i_wb.value : regs[i_rs1];
    assign o_rs2_value = (wr_en && i_wb.rd == i_rs2) ? i_wb.value : regs[i_rs2];

endmodule

//--- source/rv_decode.sv
`timescale 1ns/10ps

`include "rv_isa.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_arst_n,
    input  logic     i_stall,       // Insert a bubble, IF/ID holds
    input  logic     i_flush,       // Insert a bubble
    input  if_id_t   i_if_id,
    input  word_t    i_rs1_value,
    input  word_t    i_rs2_value,
    input  wb_t      i_ex_fwd,      // One instruction ahead
    input  wb_t      i_wb,          // Two instructions ahead
    output reg_idx_t o_rs1,
    output reg_idx_t o_rs2,
    output id_ex_t   o_id_ex
);

    opcode_e  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t rd;
    word_t    imm_i;
    word_t    imm_u;
    word_t    rs1_value;
    word_t    rs2_value;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    logic     supported;
    logic     load;

    logic     valid_q;
    addr_t    pc_q;
    alu_op_e  alu_op_q;
    word_t    operand_a_q;
    word_t    operand_b_q;
    reg_idx_t rd_q;
    logic     writes_rd_q;

    function automatic word_t bypass(input reg_idx_t idx, input word_t rf_value,
                                     input wb_t ex_fwd, input wb_t wb);
        word_t value;
        value = rf_value;
        if (idx != '0 && ex_fwd.valid && ex_fwd.rd == idx)
        begin
            value = ex_fwd.value;   // Younger result wins
        end
        else if (idx != '0 && wb.valid && wb.rd == idx)
        begin
            value = wb.value;
        end
        return value;
    endfunction

    assign opcode = opcode_e'(i_if_id.inst[6:0]);
    assign rd     = i_if_id.inst[11:7];
    assign funct3 = i_if_id.inst[14:12];
    assign o_rs1  = i_if_id.inst[19:15];
    assign o_rs2  = i_if_id.inst[24:20];
    assign funct7 = i_if_id.inst[31:25];
    assign imm_i  = {{20{i_if_id.inst[31]}}, i_if_id.inst[31:20]};
    assign imm_u  = {i_if_id.inst[31:12], 12'b0};

    assign rs1_value = bypass(o_rs1, i_rs1_value, i_ex_fwd, i_wb);
    assign rs2_value = bypass(o_rs2, i_rs2_value, i_ex_fwd, i_wb);

    always_comb
    begin
        alu_op    = alu_add;
        operand_a = rs1_value;
        operand_b = rs2_value;
        supported = 1'b0;
        case (funct3)
            `RV_F3_ADD_SUB: alu_op = (opcode == opc_op && funct7 == `RV_F7_ALT) ? alu_sub
                                                                               : alu_add;
            `RV_F3_SLL:     alu_op = alu_sll;
            `RV_F3_SLT:     alu_op = alu_slt;
            `RV_F3_SLTU:    alu_op = alu_sltu;
            `RV_F3_XOR:     alu_op = alu_xor;
            `RV_F3_SRL_SRA: alu_op = (funct7 == `RV_F7_ALT) ? alu_sra : alu_srl;
            `RV_F3_OR:      alu_op = alu_or;
            default:        alu_op = alu_and;
        endcase
        case (opcode)
            opc_op:
            begin
                supported = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT &&
                            (funct3 == `RV_F3_ADD_SUB || funct3 == `RV_F3_SRL_SRA));
            end
            opc_op_imm:
            begin
                operand_b = imm_i;
                if (funct3 == `RV_F3_SLL)
                    supported = (funct7 == `RV_F7_BASE);
                else if (funct3 == `RV_F3_SRL_SRA)
                    supported = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT);
                else
                    supported = 1'b1;
            end
            opc_lui:
            begin
                alu_op    = alu_pass_b;
                operand_a = '0;
                operand_b = imm_u;
                supported = 1'b1;
            end
            opc_auipc:
            begin
                alu_op    = alu_add;
                operand_a = i_if_id.pc;     // PC relative
                operand_b = imm_u;
                supported = 1'b1;
            end
            default: supported = 1'b0;      // Becomes a bubble
        endcase
    end

    assign load = i_if_id.valid && supported && !i_stall && !i_flush;

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= load;
    end

    always_ff @(posedge i_clock)
    begin
        pc_q        <= i_if_id.pc;
        alu_op_q    <= alu_op;
        operand_a_q <= operand_a;
        operand_b_q <= operand_b;
        rd_q        <= rd;
        writes_rd_q <= supported;   // Every supported opcode has an rd
    end

    assign o_id_ex = '{valid: valid_q, pc: pc_q, alu_op: alu_op_q, operand_a: operand_a_q,
                       operand_b: operand_b_q, rd: rd_q, writes_rd: writes_rd_q};

endmodule

//--- source/rv_execute.sv
`timescale 1ns/10ps

module rv_execute
    import rv_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_arst_n,
    input  id_ex_t i_id_ex,
    output wb_t    o_ex_fwd,        // Unregistered, for decode bypass
    output wb_t    o_wb
);

    word_t    a;
    word_t    b;
    logic [4:0] shamt;
    word_t    result;
    logic     valid_q;
    addr_t    pc_q;
    reg_idx_t rd_q;
    word_t    value_q;

    assign a     = i_id_ex.operand_a;
    assign b     = i_id_ex.operand_b;
    assign shamt = b[4:0];

    always_comb
    begin
        case (i_id_ex.alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = word_t'($signed(a) < $signed(b));
            alu_sltu:   result = word_t'(a < b);
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);   // Sign fill
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    assign o_ex_fwd = '{valid: i_id_ex.valid && i_id_ex.writes_rd, pc: i_id_ex.pc,
                        rd: i_id_ex.rd, value: result};

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= o_ex_fwd.valid;
    end

    always_ff @(posedge i_clock)
    begin
        pc_q    <= i_id_ex.pc;
        rd_q    <= i_id_ex.rd;
        value_q <= result;
    end

    assign o_wb = '{valid: valid_q, pc: pc_q, rd: rd_q, value: value_q};

endmodule

//--- source/rv_core.sv
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
#(
    parameter addr_t reset_pc = '0
)
(
    input  logic  i_clock,
    input  logic  i_arst_n,
    input  inst_t i_fetch_inst,     // Returned in the same cycle
    input  logic  i_stall,
    input  logic  i_redirect,
    input  addr_t i_redirect_pc,
    output addr_t o_fetch_pc,
    output wb_t   o_wb              // One struct per retired instruction
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    wb_t      ex_fwd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_value;
    word_t    rs2_value;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) fetch_i (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_pc          (o_fetch_pc)
    );

    rv_pipe_if_id if_id_i (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_flush  (i_redirect),
        .i_pc     (o_fetch_pc),
        .i_inst   (i_fetch_inst),
        .o_if_id  (if_id)
    );

    rv_regfile regfile_i (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_wb        (o_wb),
        .o_rs1_value (rs1_value),
        .o_rs2_value (rs2_value)
    );

    rv_decode decode_i (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_stall     (i_stall),
        .i_flush     (i_redirect),
        .i_if_id     (if_id),
        .i_rs1_value (rs1_value),
        .i_rs2_value (rs2_value),
        .i_ex_fwd    (ex_fwd),
        .i_wb        (o_wb),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_id_ex     (id_ex)
    );

    rv_execute execute_i (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_id_ex  (id_ex),
        .o_ex_fwd (ex_fwd),
        .o_wb     (o_wb)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
(
    output logic o_clock
);

    initial
    begin
        o_clock = 1'b0;
        forever
        begin
            #2 o_clock = ~o_clock;      // 4 ns period
        end
    end

endmodule

//--- test/tb_rv_core.sv
`timescale 1ns/10ps

`include "rv_isa.svh"

module tb_rv_core
    import rv_pkg::*;
();

    localparam int retire_target = 2000;
    localparam int cycle_limit   = 10000;

    logic  clock;
    logic  arst_n;
    logic  stall;
    logic  redirect;
    addr_t redirect_pc;
    addr_t fetch_pc;
    inst_t fetch_inst;
    wb_t   o_wb;

    logic [31:0] lcg_state;
    inst_t       imem [0:63];
    word_t       model_regs [0:31];
    addr_t       expected_pc;
    addr_t       expected_fetch_pc;
    addr_t       redirect_q [$];        // Target of the redirect driven last
    int          retired;
    int          cycles;

    tb_clock clock_i (.o_clock(clock));

    assign fetch_inst = imem[fetch_pc[7:2]];  // Always ready, same cycle

    rv_core dut_i (
        .i_clock       (clock),
        .i_arst_n      (arst_n),
        .i_fetch_inst  (fetch_inst),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_fetch_pc    (fetch_pc),
        .o_wb          (o_wb)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];        // Upper bits are the better ones
    endfunction

    function automatic reg_idx_t random_reg();
        logic [15:0] r;
        r = lcg_next();
        return (r[15:14] == 2'b00) ? r[4:0] : {2'b00, r[2:0]};   // Mostly x0..x7
    endfunction

    function automatic inst_t random_inst();
        logic [15:0] r;
        logic [15:0] u;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        r   = lcg_next();
        u   = lcg_next();
        f3  = r[2:0];
        imm = u[11:0];
        rd  = random_reg();
        rs1 = random_reg();
        rs2 = random_reg();
        f7  = (r[3] && (f3 == `RV_F3_ADD_SUB || f3 == `RV_F3_SRL_SRA)) ? `RV_F7_ALT
                                                                      : `RV_F7_BASE;
        case (r[5:4])
            2'd0: return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
            2'd1:
            begin
                if (f3 == `RV_F3_SLL || f3 == `RV_F3_SRL_SRA)
                    imm[11:5] = f7;     // Shift immediates carry funct7
                return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
            end
            2'd2: return {u, r[15:12], rd, `RV_OPC_LUI};
            default: return {u, r[15:12], rd, `RV_OPC_AUIPC};
        endcase
    endfunction

    // Reference ALU built from the ISA encodings
    function automatic word_t model_result(input inst_t inst, input addr_t pc);
        logic [2:0] f3;
        logic       alt;
        word_t      a;
        word_t      b;
        word_t      result;
        f3  = inst[14:12];
        alt = (inst[31:25] == `RV_F7_ALT);
        a   = model_regs[inst[19:15]];
        b   = model_regs[inst[24:20]];
        if (inst[6:0] == `RV_OPC_LUI)
            return {inst[31:12], 12'b0};
        if (inst[6:0] == `RV_OPC_AUIPC)
            return pc + {inst[31:12], 12'b0};
        if (inst[6:0] == `RV_OPC_OP_IMM)
        begin
            b = {{20{inst[31]}}, inst[31:20]};
            if (f3 == `RV_F3_ADD_SUB)
                alt = 1'b0;             // No SUBI, bit 30 is immediate
        end
        case (f3)
            `RV_F3_ADD_SUB: result = alt ? a - b : a + b;
            `RV_F3_SLL:     result = a << b[4:0];
            `RV_F3_SLT:     result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `RV_F3_SLTU:    result = (a < b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:     result = a ^ b;
            `RV_F3_SRL_SRA:
            begin
                if (alt)
                    result = $signed(a) >>> b[4:0];
                else
                    result = a >> b[4:0];
            end
            `RV_F3_OR:      result = a | b;
            default:        result = a & b;
        endcase
        return result;
    endfunction

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp_value);
        $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp_value);
        stop_run();
    endtask

    // PC the fetch stage should show after the coming rising edge
    task automatic advance_fetch_model();
        if (redirect)
            expected_fetch_pc = redirect_pc;    // Redirect wins over stall
        else if (!stall)
            expected_fetch_pc = expected_fetch_pc + 32'd4;
    endtask

    task automatic compare_fetch_pc();
        assert (fetch_pc == expected_fetch_pc)
        else report_mismatch("o_fetch_pc", fetch_pc, expected_fetch_pc);
    endtask

    task automatic check_retire();
        inst_t    inst;
        word_t    exp_value;
        reg_idx_t exp_rd;
        assert (o_wb.pc == expected_pc)
        else report_mismatch("o_wb.pc", o_wb.pc, expected_pc);
        inst      = imem[o_wb.pc[7:2]];
        exp_rd    = inst[11:7];
        exp_value = model_result(inst, o_wb.pc);
        assert (o_wb.rd == exp_rd)
        else report_mismatch("o_wb.rd", word_t'(o_wb.rd), word_t'(exp_rd));
        assert (o_wb.value == exp_value)
        else report_mismatch("o_wb.value", o_wb.value, exp_value);
        if (exp_rd != '0)
            model_regs[exp_rd] = exp_value;     // x0 stays zero
        expected_pc = expected_pc + 32'd4;
        retired++;
    endtask

    task automatic drive_random_inputs();
        logic [15:0] r;
        r     = lcg_next();
        stall = (r[2:0] == 3'd0);       // About one cycle in eight
        r     = lcg_next();
        redirect = (r % 20 == 0);
        if (redirect)
        begin
            r           = lcg_next();
            redirect_pc = {24'b0, r[5:0], 2'b00};
            redirect_q.push_back(redirect_pc);
        end
    endtask

    task automatic observe_cycle();
        if (o_wb.valid)
            check_retire();             // May still be the one in execute
        if (redirect_q.size() != 0)
            expected_pc = redirect_q.pop_front();
    endtask

    task automatic wait_first_retire();
        int wait_cycles;
        wait_cycles = 0;
        do
        begin
            advance_fetch_model();
            @(negedge clock);
            wait_cycles++;
            compare_fetch_pc();
            if (wait_cycles > 10)
            begin
                $display("Timeout: no instruction retired within 10 cycles after reset");
                stop_run();
            end
        end
        while (!o_wb.valid);
        assert (wait_cycles == 3)
        else report_mismatch("first retire cycle", word_t'(wait_cycles), 32'd3);
        check_retire();
    endtask

    initial
    begin
        arst_n            = 1'b0;
        stall             = 1'b0;
        redirect          = 1'b0;
        redirect_pc       = '0;
        lcg_state         = 32'h917a;
        expected_pc       = '0;
        expected_fetch_pc = '0;
        retired           = 0;
        cycles            = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            imem[i] = random_inst();
        repeat (3)
        begin
            @(negedge clock);
            assert (!o_wb.valid)
            else report_mismatch("o_wb.valid", word_t'(o_wb.valid), '0);
            compare_fetch_pc();         // Held at the reset PC
        end
        arst_n = 1'b1;
        wait_first_retire();
        while (retired < retire_target && cycles < cycle_limit)
        begin
            drive_random_inputs();
            advance_fetch_model();
            @(negedge clock);
            cycles++;
            compare_fetch_pc();
            observe_cycle();
        end
        if (retired >= retire_target)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("Timeout: only %0d instructions retired in %0d cycles", retired, cycles);
            stop_run();
        end
    end

endmodule

//--- flist.f
+incdir+include
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_pipe_if_id.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv
